// File: logic/input_router_pkg.sv
// Shared types for the player input router, imported by the RTL and the testbench
// Joystick words follow the core layout, with HID buttons already reordered

package input_router_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////

    // Player slots and USB pads
    localparam int NUM_PLAYERS = 4;
    // DIP bytes held from the download stream
    localparam int DIP_BYTES = 8;

    ////////////////////////////////////////
    // Joystick word layout
    ////////////////////////////////////////

    // Bits 3..0 dpad, 6..4 A B C, 9..7 D E F
    localparam int JOY_START  = 10;
    localparam int JOY_COIN   = 11;
    // Start 2 and pause only ever come from USB pads
    localparam int JOY_START2 = 12;
    localparam int JOY_PAUSE  = 13;

    // Top 6 bits unused
    typedef logic [19:0] joy_word_t;

    // One word per slot or USB pad, index 0 is player 1
    typedef joy_word_t [NUM_PLAYERS-1:0] joy_set_t;

    // Keyboard player word, low 10 bits reach the game
    typedef logic [15:0] key_word_t;

    // Player input word sent to the game
    typedef logic [9:0] player_word_t;

    ////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////

    // Contents of one LLAPI controller port
    typedef struct packed {
        logic        en;
        logic [7:0]  pad_type;
        logic [31:0] buttons;
    } llapi_pad_t;

    // Start is one bit per player
    typedef struct packed {
        logic [NUM_PLAYERS-1:0] start;
        logic                   coin;
        logic                   pause;
    } arcade_ctrl_t;

    // Download write stream
    typedef struct packed {
        logic        wr;
        logic [7:0]  index;
        logic [24:0] addr;
        logic [7:0]  data;
    } ioctl_wr_t;

endpackage

// File: logic/llapi_port.sv
// One LLAPI controller port: presence detection, HID to joystick remap
// and the down + start + first button menu combo

`timescale 1ns/1ps

module llapi_port
    import input_router_pkg::*;
(
    input  logic       clk_sys,
    input  logic       reset,
    input  llapi_pad_t pad,
    output joy_word_t  joy,
    output logic       in_use,
    output logic       menu_combo
);

    // Sticky flag, any button ever pressed since reset
    logic button_seen;
    // Pad type is a real controller id (0 and 255 mean none or unknown)
    logic type_valid;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            button_seen <= 1'b0;
        end else if (|pad.buttons) begin
            button_seen <= 1'b1;
        end
    end

    ////////////////////////////////////////
    // Presence
    ////////////////////////////////////////

    // Type 0 is also an Atari pad, so it only counts once a button was seen
    assign type_valid = (|pad.pad_type) && !(&pad.pad_type);
    assign in_use     = pad.en && (type_valid || button_seen);

    ////////////////////////////////////////
    // Remap
    ////////////////////////////////////////

    always_comb begin
        joy = '0;
        // Dpad, HID 27..24 map straight onto bits 3..0
        joy[3:0] = pad.buttons[27:24];
        // A B C
        joy[4] = pad.buttons[0];
        joy[5] = pad.buttons[1];
        joy[6] = pad.buttons[2];
        // D E F, note E and F skip over start and coin
        joy[7] = pad.buttons[3];
        joy[8] = pad.buttons[6];
        joy[9] = pad.buttons[7];
        joy[JOY_START] = pad.buttons[5];
        joy[JOY_COIN]  = pad.buttons[4];
    end

    // Down + start + A, independent of en
    assign menu_combo = pad.buttons[26] & pad.buttons[5] & pad.buttons[0];

endmodule

// File: logic/player_slot_mux.sv
// Places LLAPI pads on the lowest player slots and shifts USB pads up
// into whatever slots are left

`timescale 1ns/1ps

module player_slot_mux
    import input_router_pkg::*;
(
    input  joy_word_t ll_joy_a,
    input  joy_word_t ll_joy_b,
    input  logic      ll_use_a,
    input  logic      ll_use_b,
    input  joy_set_t  usb_joy,
    output joy_set_t  slot_joy
);

    always_comb begin
        if (ll_use_a && ll_use_b) begin
            // Both LLAPI pads present
            slot_joy[0] = ll_joy_a;
            slot_joy[1] = ll_joy_b;
            slot_joy[2] = usb_joy[0];
            slot_joy[3] = usb_joy[1];
        end else if (ll_use_a ^ ll_use_b) begin
            // One LLAPI pad, USB 0 fills the other low slot
            slot_joy[0] = ll_use_a ? ll_joy_a : usb_joy[0];
            slot_joy[1] = ll_use_b ? ll_joy_b : usb_joy[0];
            slot_joy[2] = usb_joy[1];
            slot_joy[3] = usb_joy[2];
        end else begin
            // USB only
            slot_joy = usb_joy;
        end
    end

endmodule

// File: logic/arcade_control_merge.sv
// Merges keyboard players with the slot joysticks and derives the
// start, coin and pause controls for the game

`timescale 1ns/1ps

module arcade_control_merge
    import input_router_pkg::*;
(
    input  joy_set_t                        slot_joy,
    input  key_word_t    [NUM_PLAYERS-1:0] keyboard,
    input  logic         [NUM_PLAYERS-1:0] key_start,
    input  logic         [NUM_PLAYERS-1:0] key_coin,
    input  logic                            key_pause,
    output player_word_t [NUM_PLAYERS-1:0] player_in,
    output arcade_ctrl_t                    ctrl
);

    // OR of all slots, for controls any pad may raise
    joy_word_t joy_combined;

    always_comb begin
        joy_combined = '0;
        for (int i = 0; i < NUM_PLAYERS; i++) begin
            joy_combined = joy_combined | slot_joy[i];
        end
    end

    ////////////////////////////////////////
    // Player words
    ////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < NUM_PLAYERS; i++) begin
            player_in[i] = keyboard[i][9:0] | slot_joy[i][9:0];
        end
    end

    ////////////////////////////////////////
    // Start, coin, pause
    ////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < NUM_PLAYERS; i++) begin
            ctrl.start[i] = slot_joy[i][JOY_START] | key_start[i];
        end
        // USB start 2 button goes to player 2 from any pad
        ctrl.start[1] = ctrl.start[1] | joy_combined[JOY_START2];
        // Single coin slot
        ctrl.coin  = joy_combined[JOY_COIN] | (|key_coin);
        ctrl.pause = joy_combined[JOY_PAUSE] | key_pause;
    end

endmodule

// File: logic/dip_switch_bank.sv
// DIP switch bytes captured from the download stream
// Bytes are active low and read all off after reset

`timescale 1ns/1ps

module dip_switch_bank
    import input_router_pkg::*;
#(
    parameter logic [7:0] DIP_INDEX     = 8'd254,
    parameter int         DIP_OUT_BYTES = 3
) (
    input  logic                          clk_sys,
    input  logic                          reset,
    input  ioctl_wr_t                     ioctl,
    output logic [DIP_OUT_BYTES-1:0][7:0] dip_sw
);

    localparam int SEL_W = $clog2(DIP_BYTES);

    logic [7:0] dip_mem [DIP_BYTES];
    logic       dip_hit;

    // Only the first DIP_BYTES addresses of the DIP index are switch bytes
    assign dip_hit = ioctl.wr && (ioctl.index == DIP_INDEX) &&
                     (ioctl.addr[$bits(ioctl.addr)-1:SEL_W] == '0);

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            for (int i = 0; i < DIP_BYTES; i++) begin
                dip_mem[i] <= 8'hff;
            end
        end else if (dip_hit) begin
            dip_mem[ioctl.addr[SEL_W-1:0]] <= ioctl.data;
        end
    end

    // Game sees the low bytes only, byte 0 lowest
    always_comb begin
        for (int i = 0; i < DIP_OUT_BYTES; i++) begin
            dip_sw[i] = dip_mem[i];
        end
    end

endmodule

// File: logic/input_router_top.sv
// Player input router top: two LLAPI ports, USB slot shifting, keyboard merge
// and DIP capture. Set DIP_INDEX and DIP_OUT_BYTES to match the core

`timescale 1ns/1ps

module input_router_top
    import input_router_pkg::*;
#(
    parameter logic [7:0] DIP_INDEX     = 8'd254,
    parameter int         DIP_OUT_BYTES = 3
) (
    input  logic                            clk_sys,
    input  logic                            reset,
    input  llapi_pad_t                      llapi_a,
    input  llapi_pad_t                      llapi_b,
    input  joy_set_t                        usb_joy,
    input  key_word_t    [NUM_PLAYERS-1:0] keyboard,
    input  logic         [NUM_PLAYERS-1:0] key_start,
    input  logic         [NUM_PLAYERS-1:0] key_coin,
    input  logic                            key_pause,
    input  ioctl_wr_t                       ioctl,
    output player_word_t [NUM_PLAYERS-1:0] player_in,
    output arcade_ctrl_t                    ctrl,
    output logic                            osd_button,
    output logic  [DIP_OUT_BYTES-1:0][7:0]  dip_sw
);

    joy_word_t joy_ll_a;
    joy_word_t joy_ll_b;
    logic      use_ll_a;
    logic      use_ll_b;
    logic      combo_a;
    logic      combo_b;
    joy_set_t  slot_joy;

    ////////////////////////////////////////
    // LLAPI ports
    ////////////////////////////////////////

    llapi_port port_a (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .pad        (llapi_a),
        .joy        (joy_ll_a),
        .in_use     (use_ll_a),
        .menu_combo (combo_a)
    );

    llapi_port port_b (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .pad        (llapi_b),
        .joy        (joy_ll_b),
        .in_use     (use_ll_b),
        .menu_combo (combo_b)
    );

    // Menu combo on either port opens the OSD
    assign osd_button = combo_a | combo_b;

    ////////////////////////////////////////
    // Slots and merge
    ////////////////////////////////////////

    player_slot_mux player_slot_mux_inst (
        .ll_joy_a (joy_ll_a),
        .ll_joy_b (joy_ll_b),
        .ll_use_a (use_ll_a),
        .ll_use_b (use_ll_b),
        .usb_joy  (usb_joy),
        .slot_joy (slot_joy)
    );

    arcade_control_merge arcade_control_merge_inst (
        .slot_joy  (slot_joy),
        .keyboard  (keyboard),
        .key_start (key_start),
        .key_coin  (key_coin),
        .key_pause (key_pause),
        .player_in (player_in),
        .ctrl      (ctrl)
    );

    // DIP switches
    dip_switch_bank #(
        .DIP_INDEX     (DIP_INDEX),
        .DIP_OUT_BYTES (DIP_OUT_BYTES)
    ) dip_switch_bank_inst (
        .clk_sys (clk_sys),
        .reset   (reset),
        .ioctl   (ioctl),
        .dip_sw  (dip_sw)
    );

endmodule

// File: verification/input_router_model.svh
// Reference model of the player input router, built from the routing rules
// Included inside the testbench module after the package import

`ifndef INPUT_ROUTER_MODEL_SVH
`define INPUT_ROUTER_MODEL_SVH

// HID bit that feeds each used bit of the joystick word
function automatic int hid_source(input int core_bit);
    case (core_bit)
        0: return 24;
        1: return 25;
        2: return 26;
        3: return 27;
        8: return 6;
        9: return 7;
        10: return 5;
        11: return 4;
        default: return core_bit - 4;
    endcase
endfunction

function automatic joy_word_t remap_hid(input logic [31:0] hid);
    joy_word_t j;
    j = '0;
    for (int b = 0; b < 12; b++) begin
        j[b] = hid[hid_source(b)];
    end
    return j;
endfunction

function automatic bit pad_present(input llapi_pad_t pad, input bit seen);
    bit known_type;
    known_type = (pad.pad_type != 8'd0) && (pad.pad_type != 8'd255);
    return pad.en && (known_type || seen);
endfunction

function automatic joy_set_t assign_slots(input joy_word_t ja, input joy_word_t jb,
                                          input bit ua, input bit ub, input joy_set_t usb);
    joy_set_t s;
    s = usb;
    if (ua && ub) begin
        s[0] = ja;
        s[1] = jb;
        s[2] = usb[0];
        s[3] = usb[1];
    end else if (ua || ub) begin
        // The free low slot takes USB 0, the rest shift up by one
        s[0] = ua ? ja : usb[0];
        s[1] = ub ? jb : usb[0];
        s[2] = usb[1];
        s[3] = usb[2];
    end
    return s;
endfunction

function automatic player_word_t expected_player(input key_word_t key, input joy_word_t slot);
    return key[9:0] | slot[9:0];
endfunction

function automatic arcade_ctrl_t expected_ctrl(input joy_set_t slots, input logic [3:0] ks,
                                               input logic [3:0] kc, input logic kp);
    arcade_ctrl_t c;
    logic any_start2;
    logic any_coin;
    logic any_pause;
    any_start2 = 1'b0;
    any_coin   = |kc;
    any_pause  = kp;
    for (int i = 0; i < NUM_PLAYERS; i++) begin
        c.start[i] = slots[i][10] | ks[i];
        any_start2 = any_start2 | slots[i][12];
        any_coin   = any_coin | slots[i][11];
        any_pause  = any_pause | slots[i][13];
    end
    c.start[1] = c.start[1] | any_start2;
    c.coin     = any_coin;
    c.pause    = any_pause;
    return c;
endfunction

// Down, start and first button, en plays no part
function automatic bit expected_menu(input llapi_pad_t a, input llapi_pad_t b);
    return (a.buttons[26] && a.buttons[5] && a.buttons[0]) ||
           (b.buttons[26] && b.buttons[5] && b.buttons[0]);
endfunction

function automatic bit dip_write_hits(input ioctl_wr_t w, input logic [7:0] dip_index);
    return w.wr && (w.index == dip_index) && (w.addr[24:3] == '0);
endfunction

`endif

// File: verification/input_router_tb.sv
// Testbench for the player input router with xorshift stimulus in phases
// Every output is checked one step after each clock edge against the model

`timescale 1ns/1ps

module input_router_tb
    import input_router_pkg::*;
();

    `include "input_router_model.svh"

    localparam int         RESET_CYCLES    = 5;
    localparam logic [7:0] DIP_INDEX       = 8'd254;
    localparam int         DIP_OUT_BYTES   = 3;
    localparam int         PRESENCE_CYCLES = 60;
    localparam int         COMBO_CYCLES    = 150;
    localparam int         CTRL_CYCLES     = 400;
    localparam int         MENU_CYCLES     = 300;
    localparam int         DIP_CYCLES      = 400;
    localparam int         PLANNED_CYCLES  = 2 * RESET_CYCLES + 10 + PRESENCE_CYCLES + 28 +
                                             4 * COMBO_CYCLES + CTRL_CYCLES + MENU_CYCLES +
                                             DIP_CYCLES + 10;
    localparam int         TIMEOUT_CYCLES  = 2 * PLANNED_CYCLES;

    logic                             clk_sys = 1'b0;
    logic                             reset;
    llapi_pad_t                       llapi_a;
    llapi_pad_t                       llapi_b;
    joy_set_t                         usb_joy;
    key_word_t    [NUM_PLAYERS-1:0]   keyboard;
    logic         [NUM_PLAYERS-1:0]   key_start;
    logic         [NUM_PLAYERS-1:0]   key_coin;
    logic                             key_pause;
    ioctl_wr_t                        ioctl;
    player_word_t [NUM_PLAYERS-1:0]   player_in;
    arcade_ctrl_t                     ctrl;
    logic                             osd_button;
    logic         [DIP_OUT_BYTES-1:0][7:0] dip_sw;

    // Model state and the inputs seen at the last edge
    bit          seen_a;
    bit          seen_b;
    logic [7:0]  dip_model [DIP_BYTES];
    logic        prev_reset = 1'b1;
    llapi_pad_t  prev_a;
    llapi_pad_t  prev_b;
    ioctl_wr_t   prev_ioctl = '0;
    int          cycle_count = 0;
    logic [31:0] rng_state = 32'hf378;

    always #5 clk_sys = ~clk_sys;

    input_router_top input_router_top_inst (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .llapi_a    (llapi_a),
        .llapi_b    (llapi_b),
        .usb_joy    (usb_joy),
        .keyboard   (keyboard),
        .key_start  (key_start),
        .key_coin   (key_coin),
        .key_pause  (key_pause),
        .ioctl      (ioctl),
        .player_in  (player_in),
        .ctrl       (ctrl),
        .osd_button (osd_button),
        .dip_sw     (dip_sw)
    );

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped at the first failure");
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // About one bit in eight set
    function automatic logic [31:0] sparse_random();
        return next_random() & next_random() & next_random();
    endfunction

    function automatic logic [7:0] valid_pad_type();
        return 8'(1 + next_random() % 254);
    endfunction

    function automatic logic [7:0] pick_pad_type();
        logic [31:0] r;
        r = next_random();
        if (r % 3 == 0) begin
            return 8'd0;
        end else if (r % 3 == 1) begin
            return 8'hff;
        end else begin
            return valid_pad_type();
        end
    endfunction

    function automatic llapi_pad_t make_pad(input logic en, input logic [7:0] ptype,
                                            input logic [31:0] buttons);
        llapi_pad_t p;
        p.en       = en;
        p.pad_type = ptype;
        p.buttons  = buttons;
        return p;
    endfunction

    // Sparse control bits 13..10 keep start, coin and pause from saturating
    function automatic joy_set_t random_usb();
        joy_set_t    s;
        logic [31:0] r;
        logic [31:0] c;
        for (int i = 0; i < NUM_PLAYERS; i++) begin
            r = next_random();
            c = sparse_random();
            s[i] = r[19:0];
            s[i][13:10] = c[3:0];
        end
        return s;
    endfunction

    function automatic logic [31:0] menu_buttons();
        logic [31:0] combo_mask;
        logic [31:0] b;
        logic [31:0] r;
        combo_mask = (32'd1 << 26) | (32'd1 << 5) | 32'd1;
        b = next_random();
        r = next_random();
        case (r[1:0])
            2'd0: b = b | combo_mask;
            2'd1: b = b & ~combo_mask;
            2'd2: b = (b | combo_mask) & ~(32'd1 << 5);
            default: b = b;
        endcase
        return b;
    endfunction

    task automatic drive_keys(input bit active);
        key_word_t [NUM_PLAYERS-1:0] kb;
        logic [31:0] r;
        for (int i = 0; i < NUM_PLAYERS; i++) begin
            r = sparse_random();
            kb[i] = active ? r[15:0] : '0;
        end
        r = sparse_random();
        keyboard  <= kb;
        key_start <= active ? r[3:0] : '0;
        key_coin  <= active ? r[7:4] : '0;
        key_pause <= active ? r[8] : 1'b0;
    endtask

    task automatic apply_reset();
        @(posedge clk_sys);
        reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_sys);
        reset <= 1'b0;
    endtask

    ////////////////////////////////////////
    // Test phases
    ////////////////////////////////////////

    task automatic exercise_presence();
        logic [31:0] r;
        repeat (PRESENCE_CYCLES) begin
            @(posedge clk_sys);
            r = next_random();
            llapi_a <= make_pad(r[0], pick_pad_type(), '0);
            llapi_b <= make_pad(r[1], pick_pad_type(), '0);
            usb_joy <= random_usb();
        end
        // One button on a type 0 pad makes it sticky in use
        @(posedge clk_sys);
        r = next_random();
        llapi_a <= make_pad(1'b1, 8'd0, 32'd1 << r[4:0]);
        llapi_b <= make_pad(1'b1, 8'd0, '0);
        repeat (20) begin
            @(posedge clk_sys);
            llapi_a <= make_pad(1'b1, pick_pad_type(), '0);
            usb_joy <= random_usb();
        end
        apply_reset();
        @(posedge clk_sys);
        llapi_a <= make_pad(1'b1, 8'd0, '0);
        repeat (5) @(posedge clk_sys);
    endtask

    task automatic sweep_remap_combos();
        for (int combo = 0; combo < 4; combo++) begin
            repeat (COMBO_CYCLES) begin
                @(posedge clk_sys);
                llapi_a <= make_pad(combo[0], valid_pad_type(), next_random());
                llapi_b <= make_pad(combo[1], valid_pad_type(), next_random());
                usb_joy <= random_usb();
                drive_keys(1'b1);
            end
        end
    endtask

    task automatic randomize_controls();
        logic [31:0] r;
        repeat (CTRL_CYCLES) begin
            @(posedge clk_sys);
            r = next_random();
            llapi_a <= make_pad(r[0], valid_pad_type(), sparse_random());
            llapi_b <= make_pad(r[1], valid_pad_type(), sparse_random());
            usb_joy <= random_usb();
            drive_keys(1'b1);
        end
    endtask

    task automatic press_menu_combos();
        logic [31:0] r;
        repeat (MENU_CYCLES) begin
            @(posedge clk_sys);
            r = next_random();
            llapi_a <= make_pad(r[0], pick_pad_type(), menu_buttons());
            llapi_b <= make_pad(r[1], pick_pad_type(), menu_buttons());
            usb_joy <= random_usb();
            drive_keys(1'b0);
        end
    endtask

    task automatic write_dip_bytes();
        ioctl_wr_t   w;
        logic [31:0] r;
        logic [31:0] a;
        @(posedge clk_sys);
        llapi_a <= make_pad(1'b1, 8'd0, '0);
        llapi_b <= make_pad(1'b1, 8'd0, '0);
        repeat (DIP_CYCLES) begin
            @(posedge clk_sys);
            r = next_random();
            a = next_random();
            w.wr    = r[0];
            w.index = (r[2:1] == 2'd0) ? r[15:8] : DIP_INDEX;
            // Mostly in range with an occasional address beyond the DIP bytes
            w.addr  = (r[4:3] == 2'd0) ? a[24:0] : {22'd0, r[7:5]};
            w.data  = r[31:24];
            ioctl <= w;
        end
        @(posedge clk_sys);
        ioctl <= '0;
        repeat (2) @(posedge clk_sys);
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial begin
        reset     = 1'b1;
        llapi_a   = make_pad(1'b1, 8'd0, '0);
        llapi_b   = make_pad(1'b1, 8'd0, '0);
        usb_joy   = '0;
        keyboard  = '0;
        key_start = '0;
        key_coin  = '0;
        key_pause = 1'b0;
        ioctl     = '0;
        repeat (RESET_CYCLES) @(posedge clk_sys);
        reset <= 1'b0;
        // USB words pass straight through while both pads idle
        repeat (10) begin
            @(posedge clk_sys);
            usb_joy <= random_usb();
        end
        exercise_presence();
        sweep_remap_combos();
        randomize_controls();
        press_menu_combos();
        write_dip_bytes();
        @(posedge clk_sys);
        #2;
        $display("SIMULATION PASSED");
        $finish;
    end

    ////////////////////////////////////////
    // Compare
    ////////////////////////////////////////

    // Model registers follow the inputs that the DUT sampled at this edge
    task automatic advance_model();
        if (prev_reset) begin
            seen_a = 1'b0;
            seen_b = 1'b0;
            for (int i = 0; i < DIP_BYTES; i++) begin
                dip_model[i] = 8'hff;
            end
        end else begin
            if (|prev_a.buttons) begin
                seen_a = 1'b1;
            end
            if (|prev_b.buttons) begin
                seen_b = 1'b1;
            end
            if (dip_write_hits(prev_ioctl, DIP_INDEX)) begin
                dip_model[prev_ioctl.addr[2:0]] = prev_ioctl.data;
            end
        end
    endtask

    initial begin : compare_outputs
        joy_set_t     exp_slots;
        arcade_ctrl_t exp_ctrl;
        bit           exp_menu;
        forever begin
            @(posedge clk_sys);
            #1;
            advance_model();
            exp_slots = assign_slots(remap_hid(llapi_a.buttons), remap_hid(llapi_b.buttons),
                                     pad_present(llapi_a, seen_a), pad_present(llapi_b, seen_b),
                                     usb_joy);
            exp_ctrl = expected_ctrl(exp_slots, key_start, key_coin, key_pause);
            exp_menu = expected_menu(llapi_a, llapi_b);
            for (int i = 0; i < NUM_PLAYERS; i++) begin
                assert (player_in[i] === expected_player(keyboard[i], exp_slots[i])) else
                    stop_with_failure($sformatf("ERR %0t: player_in[%0d] is %h, expected %h",
                        $time, i, player_in[i], expected_player(keyboard[i], exp_slots[i])));
            end
            assert (ctrl === exp_ctrl) else
                stop_with_failure($sformatf("ERR %0t: ctrl is %b, expected %b",
                    $time, ctrl, exp_ctrl));
            assert (osd_button === exp_menu) else
                stop_with_failure($sformatf("ERR %0t: osd_button is %b, expected %b",
                    $time, osd_button, exp_menu));
            for (int i = 0; i < DIP_OUT_BYTES; i++) begin
                assert (dip_sw[i] === dip_model[i]) else
                    stop_with_failure($sformatf("ERR %0t: dip_sw byte %0d is %h, expected %h",
                        $time, i, dip_sw[i], dip_model[i]));
            end
            prev_reset = reset;
            prev_a     = llapi_a;
            prev_b     = llapi_b;
            prev_ioctl = ioctl;
        end
    end

    // Run length guard
    always @(posedge clk_sys) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_with_failure($sformatf("Timeout: the run did not finish within %0d cycles",
                                        TIMEOUT_CYCLES));
        end
    end

endmodule

// File: input_router_top.f
+incdir+verification
logic/input_router_pkg.sv
logic/llapi_port.sv
logic/player_slot_mux.sv
logic/arcade_control_merge.sv
logic/dip_switch_bank.sv
logic/input_router_top.sv
verification/input_router_tb.sv
